// File: src/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // Machine word and register address sizes
  localparam int DataWidth = 16;
  localparam int RegAddrWidth = 4;

  // Opcode in instr[15:12]
  typedef enum logic [3:0] {
    OpAdd  = 4'h0,
    OpAddz = 4'h1,
    OpSub  = 4'h2,
    OpAnd  = 4'h3,
    OpNor  = 4'h4,
    OpSll  = 4'h5,
    OpSrl  = 4'h6,
    OpSra  = 4'h7,
    OpLw   = 4'h8,
    OpSw   = 4'h9,
    OpLhb  = 4'ha,
    OpLlb  = 4'hb,
    OpB    = 4'hc,
    OpJal  = 4'hd,
    OpJr   = 4'he,
    OpHlt  = 4'hf
  } opcodeE;

  // Branch condition in instr[11:9]
  typedef enum logic [2:0] {
    CondNe     = 3'd0,
    CondEq     = 3'd1,
    CondGt     = 3'd2,
    CondLt     = 3'd3,
    CondGe     = 3'd4,
    CondLe     = 3'd5,
    CondOv     = 3'd6,
    CondUncond = 3'd7
  } branchCondE;

  // ALU operation select
  typedef enum logic [2:0] {
    FuncAdd = 3'd0,
    FuncSub = 3'd1,
    FuncAnd = 3'd2,
    FuncNor = 3'd3,
    FuncSll = 3'd4,
    FuncSrl = 3'd5,
    FuncSra = 3'd6,
    FuncLhb = 3'd7
  } aluFuncE;

  // Sequencer states
  typedef enum logic [2:0] {
    StIdle      = 3'd0,
    StFetch     = 3'd1,
    StDecode    = 3'd2,
    StExecute   = 3'd3,
    StMemWait   = 3'd4,
    StWriteback = 3'd5,
    StHalted    = 3'd6
  } cpuStateE;

  // Flag update mode, bit 0 enables zr and bit 1 enables ne and ov
  localparam logic [1:0] FlagNone = 2'b00;
  localparam logic [1:0] FlagZero = 2'b01;
  localparam logic [1:0] FlagAll  = 2'b11;

endpackage

`default_nettype wire

// File: src/instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode import cpuPkg::*; (
  input  logic [DataWidth-1:0]    instr,
  input  logic [DataWidth-1:0]    pcPlusOne,
  input  logic                    zr,
  input  logic                    ne,
  input  logic                    ov,
  output logic [RegAddrWidth-1:0] srcAddr0,
  output logic [RegAddrWidth-1:0] srcAddr1,
  output logic [RegAddrWidth-1:0] dstAddr,
  output logic                    regWriteEn,
  output logic                    memReadEn,
  output logic                    memWriteEn,
  output logic                    memToReg,
  output logic                    src1Sel,
  output logic [3:0]              shamt,
  output aluFuncE                 aluFunc,
  output logic                    isJal,
  output logic                    isJr,
  output logic                    isHalt,
  output logic [DataWidth-1:0]    nextAddr
);

  opcodeE op;
  branchCondE cond;
  logic isBranch;
  logic isShift;
  logic taken;
  logic [DataWidth-1:0] branchOffset;
  logic [DataWidth-1:0] jalOffset;

  assign op = opcodeE'(instr[15:12]);
  assign cond = branchCondE'(instr[11:9]);

  // Control transfer opcodes
  assign isBranch = (op == OpB);
  assign isJal = (op == OpJal);
  assign isJr = (op == OpJr);
  assign isHalt = (op == OpHlt);
  assign isShift = (op == OpSll) || (op == OpSrl) || (op == OpSra);

  // LHB merges into its own destination, so that register is read as source 0
  assign srcAddr0 = (op == OpLhb) ? instr[11:8] : instr[7:4];

  // Shifter sits on the second operand
  // SW data register also comes through port 1 since its offset is immediate
  assign srcAddr1 = isShift ? instr[7:4] :
                    (op == OpSw) ? instr[11:8] : instr[3:0];

  // JAL links into R15
  // ADDZ sees the flags after its own execute and drops to R0 unless zr is set
  assign dstAddr = isJal ? '1 :
                   ((op == OpAddz) && !zr) ? '0 : instr[11:8];

  // All ALU class ops write back, plus loads, byte loads and the link
  assign regWriteEn = !instr[15] || (op == OpLw) || (op == OpLlb) ||
                      (op == OpLhb) || isJal;
  assign memReadEn = (op == OpLw);
  assign memWriteEn = (op == OpSw);
  assign memToReg = (op == OpLw);

  // Upper half of the opcode space takes its second operand from the immediate
  assign src1Sel = instr[15];

  // Shift amount from the immediate, LLB shifts its byte down by 8
  assign shamt = instr[15] ? 4'h8 : instr[3:0];

  always_comb begin
    case (op)
      OpSub:   aluFunc = FuncSub;
      OpAnd:   aluFunc = FuncAnd;
      OpNor:   aluFunc = FuncNor;
      OpSll:   aluFunc = FuncSll;
      OpSrl:   aluFunc = FuncSrl;
      OpSra:   aluFunc = FuncSra;
      OpLhb:   aluFunc = FuncLhb;
      // Sign extends the byte sitting in the high half
      OpLlb:   aluFunc = FuncSra;
      // ADD, ADDZ and address generation for LW and SW
      default: aluFunc = FuncAdd;
    endcase
  end

  // Branch condition against the held flags
  always_comb begin
    case (cond)
      CondNe:  taken = !zr;
      CondEq:  taken = zr;
      CondGt:  taken = !(zr || ne);
      CondLt:  taken = ne;
      CondGe:  taken = !ne;
      CondLe:  taken = ne || zr;
      CondOv:  taken = ov;
      default: taken = 1'b1;
    endcase
  end

  assign branchOffset = {{7{instr[8]}}, instr[8:0]};
  assign jalOffset = {{4{instr[11]}}, instr[11:0]};

  // JR target is a register value and gets picked in the sequencer
  assign nextAddr = (isBranch && taken) ? pcPlusOne + branchOffset :
                    isJal ? pcPlusOne + jalOffset : pcPlusOne;

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [RegAddrWidth-1:0] readAddr0,
  input  logic [RegAddrWidth-1:0] readAddr1,
  input  logic [RegAddrWidth-1:0] dbgAddr,
  input  logic [RegAddrWidth-1:0] writeAddr,
  input  logic                    writeEn,
  input  logic [DataWidth-1:0]    writeData,
  output logic [DataWidth-1:0]    readData0,
  output logic [DataWidth-1:0]    readData1,
  output logic [DataWidth-1:0]    dbgData
);

  localparam int NumRegs = 1 << RegAddrWidth;

  logic [DataWidth-1:0] regs [NumRegs];

  // R0 is never written, so it holds the zero from reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Reads are combinational, a write shows up the next cycle
  assign readData0 = regs[readAddr0];
  assign readData1 = regs[readAddr1];
  assign dbgData = regs[dbgAddr];

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import cpuPkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 aluEn,
  input  aluFuncE              func,
  input  logic [DataWidth-1:0] opA,
  input  logic [DataWidth-1:0] opB,
  input  logic [3:0]           shamt,
  input  logic [7:0]           imm8,
  input  logic [1:0]           flagMode,
  output logic [DataWidth-1:0] result,
  output logic                 zr,
  output logic                 ne,
  output logic                 ov
);

  localparam int Msb = DataWidth - 1;

  logic [DataWidth-1:0] sum;
  logic [DataWidth-1:0] diff;
  logic sumOv;
  logic diffOv;
  logic resultOv;

  assign sum = opA + opB;
  assign diff = opA - opB;

  // Signed overflow when the result sign disagrees with the operands
  assign sumOv = (opA[Msb] == opB[Msb]) && (sum[Msb] != opA[Msb]);
  assign diffOv = (opA[Msb] != opB[Msb]) && (diff[Msb] != opA[Msb]);

  always_comb begin
    resultOv = 1'b0;
    case (func)
      FuncAdd: begin
        result = sum;
        resultOv = sumOv;
      end
      FuncSub: begin
        result = diff;
        resultOv = diffOv;
      end
      FuncAnd: result = opA & opB;
      FuncNor: result = ~(opA | opB);
      // Shifter works on the second operand
      FuncSll: result = opB << shamt;
      FuncSrl: result = opB >> shamt;
      FuncSra: result = $signed(opB) >>> shamt;
      // Immediate into the high byte, low byte kept
      default: result = {imm8, opA[7:0]};
    endcase
  end

  // Flags only move on the execute cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      zr <= 1'b0;
      ne <= 1'b0;
      ov <= 1'b0;
    end else if (aluEn) begin
      if (flagMode[0]) begin
        zr <= (result == '0);
      end
      if (flagMode[1]) begin
        ne <= result[Msb];
        ov <= resultOv;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/controlFsm.sv
`timescale 1ns/10ps
`default_nettype none

module controlFsm import cpuPkg::*; #(
  parameter int MemLatency = 3
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [DataWidth-1:0] instrIn,
  input  logic                 isHalt,
  input  logic                 isJr,
  input  logic                 isJal,
  input  logic                 memReadEn,
  input  logic                 memWriteEn,
  input  logic                 memToReg,
  input  logic                 regWriteEn,
  input  logic [DataWidth-1:0] nextAddr,
  input  logic [DataWidth-1:0] jrTarget,
  input  logic [DataWidth-1:0] aluResult,
  input  logic [DataWidth-1:0] memReadData,
  input  logic                 timerDone,
  output logic [DataWidth-1:0] instrAddr,
  output logic [DataWidth-1:0] instr,
  output logic [DataWidth-1:0] pcPlusOne,
  output logic [DataWidth-1:0] regWriteData,
  output logic                 regWe,
  output logic                 aluEn,
  output logic                 dataWe,
  output logic                 timerLoad,
  output logic                 busy,
  output logic                 halted,
  output logic [DataWidth-1:0] cycleCount,
  output cpuStateE             state
);

  cpuStateE stateNext;
  logic [DataWidth-1:0] pc;
  logic [DataWidth-1:0] pcNext;
  logic startAccept;
  logic isMemAccess;

  assign busy = (state != StIdle) && (state != StHalted);
  assign halted = (state == StHalted);
  assign startAccept = start && !busy;
  assign isMemAccess = memReadEn || memWriteEn;
  assign pcPlusOne = pc + 1'b1;

  always_comb begin
    stateNext = state;
    case (state)
      StIdle, StHalted: begin
        if (start) stateNext = StFetch;
      end
      StFetch: stateNext = StDecode;
      StDecode: stateNext = isHalt ? StHalted : StExecute;
      // With no latency the access completes inside execute
      StExecute: stateNext = (isMemAccess && (MemLatency > 0)) ? StMemWait : StWriteback;
      StMemWait: begin
        if (timerDone) stateNext = StWriteback;
      end
      StWriteback: stateNext = StFetch;
      default: stateNext = StIdle;
    endcase
  end

  // PC target for the coming fetch
  always_comb begin
    pcNext = pc;
    if (startAccept) begin
      pcNext = '0;
    end else if (state == StWriteback) begin
      pcNext = isJr ? jrTarget : nextAddr;
    end
  end

  // Instruction memory reads are registered, so it sees the next PC one cycle early
  assign instrAddr = pcNext;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= StIdle;
      pc <= '0;
      cycleCount <= '0;
    end else begin
      state <= stateNext;
      pc <= pcNext;
      if (startAccept) begin
        cycleCount <= '0;
      end else if (busy) begin
        cycleCount <= cycleCount + 1'b1;
      end
    end
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if (state == StFetch) begin
      instr <= instrIn;
    end
  end

  // Strobes, one cycle each
  assign aluEn = (state == StExecute);
  assign dataWe = (state == StExecute) && memWriteEn;
  assign timerLoad = (state == StExecute) && isMemAccess;
  assign regWe = (state == StWriteback) && regWriteEn;

  // Writeback source
  assign regWriteData = isJal ? pcPlusOne :
                        memToReg ? memReadData : aluResult;

endmodule

`default_nettype wire

// File: src/waitTimer.sv
`timescale 1ns/10ps
`default_nettype none

module waitTimer #(
  parameter int MemLatency = 3
) (
  input  logic clk,
  input  logic reset,
  input  logic timerLoad,
  output logic timerDone
);

  // Room for MemLatency even when it is zero
  localparam int CountWidth = $clog2(MemLatency + 2);

  logic [CountWidth-1:0] count;

  // Counts down to zero and rests there
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (timerLoad) begin
      count <= CountWidth'(MemLatency);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Last cycle of the wait
  assign timerDone = (count == CountWidth'(1));

endmodule

`default_nettype wire

// File: src/wordMem.sv
`timescale 1ns/10ps
`default_nettype none

module wordMem import cpuPkg::*; #(
  parameter int MemDepthLog2 = 8
) (
  input  logic                    clk,
  input  logic                    writeEn,
  input  logic [MemDepthLog2-1:0] addr,
  input  logic [DataWidth-1:0]    writeData,
  output logic [DataWidth-1:0]    readData
);

  localparam int Depth = 1 << MemDepthLog2;

  logic [DataWidth-1:0] mem [Depth];

  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[addr] <= writeData;
    end
  end

  // Registered read, old contents on a same-cycle write
  always_ff @(posedge clk) begin
    readData <= mem[addr];
  end

endmodule

`default_nettype wire

// File: src/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop import cpuPkg::*; #(
  parameter int MemLatency = 3,
  parameter int MemDepthLog2 = 8
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    loadEn,
  input  logic [MemDepthLog2-1:0] loadAddr,
  input  logic [DataWidth-1:0]    loadData,
  input  logic                    start,
  output logic                    halted,
  output logic                    busy,
  output logic [DataWidth-1:0]    cycleCount,
  input  logic [RegAddrWidth-1:0] dbgAddr,
  output logic [DataWidth-1:0]    dbgData,
  output logic [2:0]              flags,
  output cpuStateE                state
);

  logic [DataWidth-1:0] instrAddr;
  logic [DataWidth-1:0] instrIn;
  logic [DataWidth-1:0] instr;
  logic [DataWidth-1:0] pcPlusOne;
  logic [DataWidth-1:0] nextAddr;
  logic [DataWidth-1:0] regWriteData;
  logic [DataWidth-1:0] readData0;
  logic [DataWidth-1:0] readData1;
  logic [DataWidth-1:0] aluResult;
  logic [DataWidth-1:0] aluOpB;
  logic [DataWidth-1:0] immWord;
  logic [DataWidth-1:0] memReadData;
  logic [MemDepthLog2-1:0] imemAddr;
  logic [RegAddrWidth-1:0] srcAddr0;
  logic [RegAddrWidth-1:0] srcAddr1;
  logic [RegAddrWidth-1:0] dstAddr;
  logic [3:0] shamt;
  logic [1:0] flagMode;
  aluFuncE aluFunc;
  logic imemWe;
  logic regWe;
  logic aluEn;
  logic dataWe;
  logic timerLoad;
  logic timerDone;
  logic regWriteEn;
  logic memReadEn;
  logic memWriteEn;
  logic memToReg;
  logic src1Sel;
  logic isJal;
  logic isJr;
  logic isHalt;
  logic aluClass;
  logic zr;
  logic ne;
  logic ov;

  // Program load port owns the instruction memory only while idle
  assign imemWe = loadEn && (state == StIdle);
  assign imemAddr = imemWe ? loadAddr : instrAddr[MemDepthLog2-1:0];

  // Immediate operand, memory offset or LLB byte placed high
  assign immWord = (memReadEn || memWriteEn) ? {{12{instr[3]}}, instr[3:0]} :
                                               {instr[7:0], 8'h00};
  assign aluOpB = src1Sel ? immWord : readData1;

  // Add and subtract set all flags, other register ops set zr
  assign aluClass = regWriteEn && !src1Sel;
  assign flagMode = !aluClass ? FlagNone :
                    ((aluFunc == FuncAdd) || (aluFunc == FuncSub)) ? FlagAll : FlagZero;

  assign flags = {zr, ne, ov};

  controlFsm #(.MemLatency(MemLatency)) sequencer (
    .clk(clk), .reset(reset), .start(start),
    .instrIn(instrIn), .isHalt(isHalt), .isJr(isJr), .isJal(isJal),
    .memReadEn(memReadEn), .memWriteEn(memWriteEn), .memToReg(memToReg),
    .regWriteEn(regWriteEn), .nextAddr(nextAddr), .jrTarget(readData0),
    .aluResult(aluResult), .memReadData(memReadData), .timerDone(timerDone),
    .instrAddr(instrAddr), .instr(instr), .pcPlusOne(pcPlusOne),
    .regWriteData(regWriteData), .regWe(regWe), .aluEn(aluEn), .dataWe(dataWe),
    .timerLoad(timerLoad), .busy(busy), .halted(halted),
    .cycleCount(cycleCount), .state(state)
  );

  waitTimer #(.MemLatency(MemLatency)) timer (
    .clk(clk), .reset(reset), .timerLoad(timerLoad), .timerDone(timerDone)
  );

  instrDecode decoder (
    .instr(instr), .pcPlusOne(pcPlusOne), .zr(zr), .ne(ne), .ov(ov),
    .srcAddr0(srcAddr0), .srcAddr1(srcAddr1), .dstAddr(dstAddr),
    .regWriteEn(regWriteEn), .memReadEn(memReadEn), .memWriteEn(memWriteEn),
    .memToReg(memToReg), .src1Sel(src1Sel), .shamt(shamt), .aluFunc(aluFunc),
    .isJal(isJal), .isJr(isJr), .isHalt(isHalt), .nextAddr(nextAddr)
  );

  regFile registers (
    .clk(clk), .reset(reset),
    .readAddr0(srcAddr0), .readAddr1(srcAddr1), .dbgAddr(dbgAddr),
    .writeAddr(dstAddr), .writeEn(regWe), .writeData(regWriteData),
    .readData0(readData0), .readData1(readData1), .dbgData(dbgData)
  );

  alu aluUnit (
    .clk(clk), .reset(reset), .aluEn(aluEn), .func(aluFunc),
    .opA(readData0), .opB(aluOpB), .shamt(shamt), .imm8(instr[7:0]),
    .flagMode(flagMode), .result(aluResult), .zr(zr), .ne(ne), .ov(ov)
  );

  wordMem #(.MemDepthLog2(MemDepthLog2)) instrMem (
    .clk(clk), .writeEn(imemWe), .addr(imemAddr),
    .writeData(loadData), .readData(instrIn)
  );

  // Store data comes from the register named in instr[11:8]
  wordMem #(.MemDepthLog2(MemDepthLog2)) dataMem (
    .clk(clk), .writeEn(dataWe), .addr(aluResult[MemDepthLog2-1:0]),
    .writeData(readData1), .readData(memReadData)
  );

endmodule

`default_nettype wire

// File: verification/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

  localparam int MemLatency = 3;
  localparam int ProgLen = 8;
  localparam int NumFixed = 13;
  localparam int NumBranch = 32;
  localparam int NumRandom = 8;
  localparam int NumTests = NumFixed + NumBranch + NumRandom;
  localparam int ClkPeriod = 100;
  localparam int DriveDelay = 5;
  // Full program of memory instructions per test, doubled
  localparam int WatchdogNs = 2 * NumTests * ProgLen * (4 + MemLatency) * ClkPeriod;
  localparam logic [15:0] HaltWord = 16'hf000;

  logic clk;
  logic reset;
  logic loadEn;
  logic [7:0] loadAddr;
  logic [15:0] loadData;
  logic start;
  logic halted;
  logic busy;
  logic [15:0] cycleCount;
  logic [3:0] dbgAddr;
  logic [15:0] dbgData;
  logic [2:0] flags;
  cpuStateE state;

  // Test table, one row per index
  string testName [NumTests];
  logic [15:0] progWords [NumTests][ProgLen];
  logic [3:0] checkReg [NumTests];
  logic [15:0] expValue [NumTests];
  logic [2:0] expFlags [NumTests];
  logic [15:0] expCycles [NumTests];
  logic rerun [NumTests];

  logic [15:0] codeQ [$];
  int numEntries;
  int errorCount;
  int failedTests;
  logic [31:0] lcgState;

  cpuTop #(.MemLatency(MemLatency), .MemDepthLog2(8)) DUT (
    .clk(clk), .reset(reset), .loadEn(loadEn), .loadAddr(loadAddr),
    .loadData(loadData), .start(start), .halted(halted), .busy(busy),
    .cycleCount(cycleCount), .dbgAddr(dbgAddr), .dbgData(dbgData),
    .flags(flags), .state(state)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the core never halted", WatchdogNs);
    $display("*** FAILED ***");
    $finish;
  end

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Register form, the last field is rt, shift amount or memory offset
  function automatic logic [15:0] regOp(opcodeE op, int rd, int rs, int rt);
    return {op, rd[3:0], rs[3:0], rt[3:0]};
  endfunction

  function automatic logic [15:0] byteOp(opcodeE op, int rd, logic [7:0] imm);
    return {op, rd[3:0], imm};
  endfunction

  function automatic logic [15:0] branchOp(branchCondE cond, logic [8:0] offset);
    return {OpB, cond, offset};
  endfunction

  // 4 per instruction, plus the memory wait, plus Fetch and Decode of HLT
  function automatic logic [15:0] cyclesFor(int plain, int mem);
    return 16'(4 * plain + (4 + MemLatency) * mem + 2);
  endfunction

  // Flag vector is {zr, ne, ov}
  function automatic logic condHolds(branchCondE cond, logic [2:0] f);
    case (cond)
      CondNe: return !f[2];
      CondEq: return f[2];
      CondGt: return !f[2] && !f[1];
      CondLt: return f[1];
      CondGe: return !f[1];
      CondLe: return f[1] || f[2];
      CondOv: return f[0];
      default: return 1'b1;
    endcase
  endfunction

  // Unused words become HLT
  function automatic void addTest(string name, int regIdx, logic [15:0] value,
                                  logic [2:0] flagsExp, logic [15:0] cycles, logic again);
    testName[numEntries] = name;
    for (int w = 0; w < ProgLen; w++) begin
      progWords[numEntries][w] = (w < codeQ.size()) ? codeQ[w] : HaltWord;
    end
    checkReg[numEntries] = regIdx[3:0];
    expValue[numEntries] = value;
    expFlags[numEntries] = flagsExp;
    expCycles[numEntries] = cycles;
    rerun[numEntries] = again;
    codeQ.delete();
    numEntries++;
  endfunction

  // Call to address 4 and return through R15
  function automatic void pushCallProgram();
    codeQ.push_back(byteOp(OpLlb, 6, 8'h01));
    codeQ.push_back({OpJal, 12'h002});
    codeQ.push_back(regOp(OpAdd, 7, 7, 6));
    codeQ.push_back(HaltWord);
    codeQ.push_back(byteOp(OpLlb, 8, 8'h11));
    codeQ.push_back({OpJr, 4'h0, 4'hf, 4'h0});
  endfunction

  task automatic buildTable();
    logic [2:0] setupFlags [4];
    string setupLabel [4];
    branchCondE cond;
    logic taken;
    logic [31:0] rnd;
    logic [7:0] a;
    logic [7:0] b;
    logic [15:0] sum;
    int setupLen;
    setupFlags = '{3'b100, 3'b010, 3'b000, 3'b001};
    setupLabel = '{"zero", "neg", "pos", "ovf"};
    codeQ.push_back(byteOp(OpLlb, 1, 8'h12));
    codeQ.push_back(byteOp(OpLlb, 2, 8'h34));
    codeQ.push_back(regOp(OpAdd, 3, 1, 2));
    addTest("llb_add", 3, 16'h0046, 3'b000, cyclesFor(3, 0), 1'b0);
    codeQ.push_back(byteOp(OpLlb, 1, 8'h25));
    codeQ.push_back(byteOp(OpLlb, 2, 8'h25));
    codeQ.push_back(regOp(OpSub, 3, 1, 2));
    addTest("sub_zero", 3, 16'h0000, 3'b100, cyclesFor(3, 0), 1'b0);
    // 0x7f7f doubled crosses into the sign bit
    codeQ.push_back(byteOp(OpLlb, 1, 8'h7f));
    codeQ.push_back(byteOp(OpLhb, 1, 8'h7f));
    codeQ.push_back(regOp(OpAdd, 2, 1, 1));
    addTest("add_overflow", 2, 16'hfefe, 3'b011, cyclesFor(3, 0), 1'b0);
    // SUB leaves ne set, positive NOR and zero AND results move zr only
    codeQ.push_back(byteOp(OpLlb, 1, 8'h3c));
    codeQ.push_back(byteOp(OpLlb, 2, 8'h0f));
    codeQ.push_back(regOp(OpSub, 5, 2, 1));
    codeQ.push_back(regOp(OpNor, 4, 5, 5));
    codeQ.push_back(regOp(OpAnd, 3, 4, 5));
    addTest("and_nor", 4, 16'h002c, 3'b110, cyclesFor(5, 0), 1'b0);
    // Non-zero ADDZ result goes to R0, R3 keeps its old value
    codeQ.push_back(byteOp(OpLlb, 3, 8'h77));
    codeQ.push_back(byteOp(OpLlb, 1, 8'h05));
    codeQ.push_back(byteOp(OpLlb, 2, 8'h03));
    codeQ.push_back(regOp(OpAddz, 3, 1, 2));
    addTest("addz_drop", 3, 16'h0077, 3'b000, cyclesFor(4, 0), 1'b0);
    codeQ.push_back(byteOp(OpLlb, 1, 8'h81));
    codeQ.push_back(regOp(OpSll, 2, 1, 4));
    addTest("shift_sll", 2, 16'hf810, 3'b000, cyclesFor(2, 0), 1'b0);
    codeQ.push_back(byteOp(OpLlb, 1, 8'h81));
    codeQ.push_back(regOp(OpSrl, 2, 1, 3));
    addTest("shift_srl", 2, 16'h1ff0, 3'b000, cyclesFor(2, 0), 1'b0);
    codeQ.push_back(byteOp(OpLlb, 1, 8'h81));
    codeQ.push_back(regOp(OpSra, 2, 1, 3));
    addTest("shift_sra", 2, 16'hfff0, 3'b000, cyclesFor(2, 0), 1'b0);
    codeQ.push_back(byteOp(OpLlb, 1, 8'h5a));
    codeQ.push_back(byteOp(OpLhb, 1, 8'hc3));
    addTest("lhb_merge", 1, 16'hc35a, 3'b000, cyclesFor(2, 0), 1'b0);
    // Store to 0x20+3, load back through 0x24-1
    codeQ.push_back(byteOp(OpLlb, 1, 8'h20));
    codeQ.push_back(byteOp(OpLlb, 2, 8'h9b));
    codeQ.push_back(byteOp(OpLhb, 2, 8'h4e));
    codeQ.push_back(regOp(OpSw, 2, 1, 3));
    codeQ.push_back(byteOp(OpLlb, 5, 8'h24));
    codeQ.push_back(regOp(OpLw, 4, 5, 4'hf));
    addTest("mem_sw_lw", 4, 16'h4e9b, 3'b000, cyclesFor(4, 2), 1'b0);
    pushCallProgram();
    addTest("jal_link", 15, 16'h0002, 3'b000, cyclesFor(5, 0), 1'b0);
    pushCallProgram();
    addTest("jr_return", 7, 16'h0001, 3'b000, cyclesFor(5, 0), 1'b0);
    // R2 accumulates, so two runs leave 10
    codeQ.push_back(byteOp(OpLlb, 1, 8'h05));
    codeQ.push_back(regOp(OpAdd, 2, 2, 1));
    codeQ.push_back(regOp(OpSw, 2, 0, 1));
    addTest("halt_restart", 2, 16'h000a, 3'b000, cyclesFor(2, 1), 1'b1);
    // Every condition against four flag patterns, taken skips the marker
    for (int s = 0; s < 4; s++) begin
      for (int c = 0; c < 8; c++) begin
        cond = branchCondE'(c);
        codeQ.push_back(byteOp(OpLlb, 6, 8'h01));
        case (s)
          0: codeQ.push_back(regOp(OpSub, 1, 0, 0));
          1: codeQ.push_back(regOp(OpSub, 1, 0, 6));
          2: codeQ.push_back(regOp(OpAdd, 1, 6, 0));
          default: begin
            codeQ.push_back(byteOp(OpLlb, 2, 8'h00));
            codeQ.push_back(byteOp(OpLhb, 2, 8'h80));
            codeQ.push_back(regOp(OpSub, 1, 2, 6));
          end
        endcase
        setupLen = (s == 3) ? 4 : 2;
        codeQ.push_back(branchOp(cond, 9'd1));
        codeQ.push_back(regOp(OpAdd, 7, 7, 6));
        taken = condHolds(cond, setupFlags[s]);
        // Marker ADD of 0 and 1 clears all flags
        addTest($sformatf("branch_%s_%s", cond.name(), setupLabel[s]), 7,
                taken ? 16'h0000 : 16'h0001, taken ? setupFlags[s] : 3'b000,
                cyclesFor(setupLen + (taken ? 1 : 2), 0), 1'b0);
      end
    end
    for (int r = 0; r < NumRandom; r++) begin
      rnd = nextRandom();
      a = rnd[23:16];
      rnd = nextRandom();
      b = rnd[23:16];
      sum = {{8{a[7]}}, a} + {{8{b[7]}}, b};
      codeQ.push_back(byteOp(OpLlb, 1, a));
      codeQ.push_back(byteOp(OpLlb, 2, b));
      codeQ.push_back(regOp(OpAdd, 3, 1, 2));
      // Two sign-extended bytes never overflow a word
      addTest($sformatf("random_add_%0d", r), 3, sum, {sum == 16'h0000, sum[15], 1'b0},
              cyclesFor(3, 0), 1'b0);
    end
  endtask

  task automatic checkWord(string sig, logic [15:0] got, logic [15:0] exp);
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic checkState(string sig, cpuStateE got, cpuStateE exp);
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t %s: got %s, expected %s", $time, sig, got.name(), exp.name());
    end
  endtask

  task automatic checkFlag(string sig, logic got, logic exp);
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, sig, got, exp);
    end
  endtask

  task automatic stepCycle();
    @(posedge clk);
    #(DriveDelay);
  endtask

  task automatic applyReset();
    reset = 1'b1;
    repeat (2) stepCycle();
    reset = 1'b0;
  endtask

  task automatic loadProgram(int idx);
    for (int w = 0; w < ProgLen; w++) begin
      loadEn = 1'b1;
      loadAddr = 8'(w);
      loadData = progWords[idx][w];
      stepCycle();
    end
    loadEn = 1'b0;
  endtask

  task automatic pulseStart();
    start = 1'b1;
    stepCycle();
    start = 1'b0;
  endtask

  // Watchdog bounds this loop
  task automatic waitHalt();
    do begin
      stepCycle();
    end while (!halted);
  endtask

  task automatic runTest(int idx);
    int errorsBefore;
    errorsBefore = errorCount;
    applyReset();
    loadProgram(idx);
    pulseStart();
    // First cycle of the run is Fetch
    checkFlag("busy after start", busy, 1'b1);
    checkFlag("halted after start", halted, 1'b0);
    if (rerun[idx]) begin
      // HLT at address 1 would cut the run short if this write landed
      loadEn = 1'b1;
      loadAddr = 8'd1;
      loadData = HaltWord;
      repeat (3) stepCycle();
      loadEn = 1'b0;
    end
    waitHalt();
    checkFlag("busy", busy, 1'b0);
    checkState("state", state, StHalted);
    checkWord("cycleCount", cycleCount, expCycles[idx]);
    if (rerun[idx]) begin
      pulseStart();
      waitHalt();
      checkState("state after restart", state, StHalted);
      checkWord("cycleCount after restart", cycleCount, expCycles[idx]);
    end
    dbgAddr = checkReg[idx];
    #1;
    checkWord($sformatf("R%0d", checkReg[idx]), dbgData, expValue[idx]);
    checkFlag("zr", flags[2], expFlags[idx][2]);
    checkFlag("ne", flags[1], expFlags[idx][1]);
    checkFlag("ov", flags[0], expFlags[idx][0]);
    if (errorCount != errorsBefore) begin
      failedTests++;
      $display("[TEST] %0d %s: %0d mismatches", idx, testName[idx], errorCount - errorsBefore);
    end else begin
      $display("[TEST] %0d %s: ok", idx, testName[idx]);
    end
  endtask

  initial begin
    reset = 1'b1;
    loadEn = 1'b0;
    loadAddr = '0;
    loadData = '0;
    start = 1'b0;
    dbgAddr = '0;
    lcgState = 32'head7cdf1;
    errorCount = 0;
    failedTests = 0;
    numEntries = 0;
    buildTable();
    if (numEntries != NumTests) begin
      errorCount++;
      $display("Test table holds %0d entries instead of %0d", numEntries, NumTests);
    end
    for (int i = 0; i < numEntries; i++) begin
      runTest(i);
    end
    $display("Tests run: %0d, failed: %0d, check errors: %0d",
             numEntries, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/cpuPkg.sv
src/instrDecode.sv
src/regFile.sv
src/alu.sv
src/controlFsm.sv
src/waitTimer.sv
src/wordMem.sv
src/cpuTop.sv
verification/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing -Wno-fatal --top-module cpuTb \
  -Mdir "$buildDir" -o cpuSim -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/cpuSim" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -qF '*** FAILED ***' "$logFile"; then
  echo "Simulation reported a failure, see $logFile"
  exit 1
fi

echo "Simulation finished without a failure"
exit 0
